// ==== verilog/dma_sink_pkg.sv ====
/*
 * Shared definitions for the network-to-memory data mover:
 * widths, buffer depth, burst limit, engine states, AXI codes
 */
package dma_sink_pkg;

    // Channels
    localparam int NUM_CH = 4;
    localparam int CH_W = 2;

    // Address and data path
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BEAT_BYTES = 4;

    // Fill buffer, per channel
    localparam int BUF_DEPTH = 16;
    localparam int PTR_W = 4;
    // Holds 0..BUF_DEPTH
    localparam int LVL_W = 5;

    // Transfer and burst sizing
    localparam int XFER_W = 16;
    localparam int MAX_BURST = 4;
    // Holds 0..MAX_BURST
    localparam int BURST_W = 3;
    localparam int LEN_W = 8;

    // AXI write response
    localparam int RESP_W = 2;
    localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

    // Write engine states
    localparam int ST_W = 2;
    localparam logic [ST_W-1:0] ST_IDLE = 2'd0;
    localparam logic [ST_W-1:0] ST_ADDR = 2'd1;
    localparam logic [ST_W-1:0] ST_DATA = 2'd2;
    localparam logic [ST_W-1:0] ST_RESP = 2'd3;

endpackage : dma_sink_pkg

// ==== verilog/dma_sink_if.sv ====
/*
 * Internal buses of the data mover: burst commands with completion
 * from scheduler to write engine, and the fill buffer read side
 */
`timescale 1ns/100ps

interface burst_cmd_if import dma_sink_pkg::*; ();

    // Command, scheduler to engine
    logic               cmd_valid;
    logic               cmd_ready;
    logic [CH_W-1:0]    cmd_chan;
    logic [ADDR_W-1:0]  cmd_addr;
    logic [BURST_W-1:0] cmd_beats;

    // Completion, engine to scheduler
    logic               done;
    logic [CH_W-1:0]    done_chan;
    logic               done_err;

    modport sched (
        output cmd_valid, cmd_chan, cmd_addr, cmd_beats,
        input  cmd_ready, done, done_chan, done_err
    );

    modport engine (
        input  cmd_valid, cmd_chan, cmd_addr, cmd_beats,
        output cmd_ready, done, done_chan, done_err
    );

endinterface : burst_cmd_if

interface fill_rd_if import dma_sink_pkg::*; ();

    // One fill count per channel
    logic [NUM_CH-1:0][LVL_W-1:0] level;
    // Oldest beat of rd_chan, combinational
    logic [DATA_W-1:0]            rd_data;
    logic [CH_W-1:0]              rd_chan;
    logic                         pop;

    modport buffer (output level, rd_data, input rd_chan, pop);
    modport engine (input rd_data, output rd_chan, pop);
    modport sched (input level);

endinterface : fill_rd_if

// ==== verilog/fill_buffer.sv ====
/*
 * Per-channel circular fill buffers sharing one memory, with
 * per-channel levels and free space toward the fill source
 */
`timescale 1ns/100ps

module fill_buffer import dma_sink_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,

    // Fill stream from the network side
    input  logic                         fill_valid,
    output logic                         fill_ready,
    input  logic [CH_W-1:0]              fill_id,
    input  logic [DATA_W-1:0]            fill_data,
    output logic [NUM_CH-1:0][LVL_W-1:0] space_free,

    // Read side toward engine and scheduler
    fill_rd_if.buffer                    rd
);

    // Channel picks the upper address bits of the shared memory
    logic [DATA_W-1:0]            mem [NUM_CH*BUF_DEPTH];

    logic [NUM_CH-1:0][PTR_W-1:0] wr_ptr;
    logic [NUM_CH-1:0][PTR_W-1:0] rd_ptr;
    logic [NUM_CH-1:0][LVL_W-1:0] level;
    logic [NUM_CH-1:0]            wr_hit;
    logic [NUM_CH-1:0]            rd_hit;
    logic                         fill_fire;

    // Full channel holds off the source
    assign fill_ready = (level[fill_id] != LVL_W'(BUF_DEPTH));
    assign fill_fire  = fill_valid && fill_ready;

    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            wr_hit[i]     = fill_fire && (fill_id == CH_W'(i));
            rd_hit[i]     = rd.pop && (rd.rd_chan == CH_W'(i));
            space_free[i] = LVL_W'(BUF_DEPTH) - level[i];
        end
    end

    // ==================================================
    // Storage
    // ==================================================

    always_ff @(posedge clk) begin
        if (fill_fire) begin
            mem[{fill_id, wr_ptr[fill_id]}] <= fill_data;
        end
    end

    // Head of the selected channel, no read latency
    assign rd.rd_data = mem[{rd.rd_chan, rd_ptr[rd.rd_chan]}];

    // ==================================================
    // Pointers and levels
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            for (int i = 0; i < NUM_CH; i++) begin
                // Pointers wrap at BUF_DEPTH on their own
                if (wr_hit[i]) begin
                    wr_ptr[i] <= wr_ptr[i] + 1'b1;
                end
                if (rd_hit[i]) begin
                    rd_ptr[i] <= rd_ptr[i] + 1'b1;
                end
                // Write and pop together cancel out
                if (wr_hit[i] && !rd_hit[i]) begin
                    level[i] <= level[i] + 1'b1;
                end else if (rd_hit[i] && !wr_hit[i]) begin
                    level[i] <= level[i] - 1'b1;
                end
            end
        end
    end

    assign rd.level = level;

    // Engine never drains a channel below empty
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (reset)
        rd.pop |-> (level[rd.rd_chan] != '0)
    ) else $error("fill_buffer: pop on empty channel %0d", rd.rd_chan);

endmodule : fill_buffer

// ==== verilog/channel_scheduler.sv ====
/*
 * Per-channel transfer tracking: takes kicks, cuts transfers into
 * bursts of up to MAX_BURST beats, grants them round robin
 */
`timescale 1ns/100ps

module channel_scheduler import dma_sink_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,

    // Kick from software
    input  logic [NUM_CH-1:0]             kick_valid,
    output logic [NUM_CH-1:0]             kick_ready,
    input  logic [NUM_CH-1:0][ADDR_W-1:0] kick_addr,
    input  logic [NUM_CH-1:0][XFER_W-1:0] kick_beats,

    // Channel status
    output logic [NUM_CH-1:0]             done_strobe,
    output logic [NUM_CH-1:0]             ch_error,

    burst_cmd_if.sched                    cmd,
    fill_rd_if.sched                      lvl
);

    // Per-channel transfer state
    logic [NUM_CH-1:0]              busy;
    logic [NUM_CH-1:0]              issued;
    logic [NUM_CH-1:0]              err;
    logic [NUM_CH-1:0][ADDR_W-1:0]  next_addr;
    logic [NUM_CH-1:0][XFER_W-1:0]  remain;
    logic [NUM_CH-1:0][BURST_W-1:0] burst_sz;

    logic [NUM_CH-1:0]              kick_fire;
    logic [NUM_CH-1:0]              done_hit;
    logic [NUM_CH-1:0]              fin;
    logic [NUM_CH-1:0]              elig;

    // Arbitration
    logic [CH_W-1:0]                last_grant;
    logic [CH_W-1:0]                grant_ch;
    logic                           any_elig;
    logic                           grant_ok;

    // Held command
    logic                           cmd_valid_r;
    logic [CH_W-1:0]                cmd_chan_r;
    logic [ADDR_W-1:0]              cmd_addr_r;
    logic [BURST_W-1:0]             cmd_beats_r;

    assign kick_ready = ~busy;
    assign kick_fire  = kick_valid & ~busy;

    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            // Smaller of remaining beats and MAX_BURST
            if (remain[i] >= XFER_W'(MAX_BURST)) begin
                burst_sz[i] = BURST_W'(MAX_BURST);
            end else begin
                burst_sz[i] = BURST_W'(remain[i]);
            end
            done_hit[i] = cmd.done && (cmd.done_chan == CH_W'(i));
            // Nothing left and no burst in flight
            fin[i]      = busy[i] && !issued[i] && (remain[i] == '0);
            elig[i]     = busy[i] && !issued[i] && (remain[i] != '0) &&
                          (lvl.level[i] >= LVL_W'(burst_sz[i]));
        end
    end

    assign done_strobe = fin;
    assign ch_error    = err;

    // ==================================================
    // Round-robin grant
    // ==================================================

    // Search starts one past the last grant
    always_comb begin
        logic [CH_W-1:0] idx;
        grant_ch = last_grant;
        any_elig = 1'b0;
        for (int k = 1; k <= NUM_CH; k++) begin
            idx = last_grant + CH_W'(k);
            if (!any_elig && elig[idx]) begin
                grant_ch = idx;
                any_elig = 1'b1;
            end
        end
    end

    // New grant only once the held command is gone
    assign grant_ok = any_elig && !cmd_valid_r;

    // ==================================================
    // Control state
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            busy        <= '0;
            issued      <= '0;
            err         <= '0;
            cmd_valid_r <= 1'b0;
            last_grant  <= CH_W'(NUM_CH - 1);
        end else begin
            for (int i = 0; i < NUM_CH; i++) begin
                if (kick_fire[i]) begin
                    busy[i]   <= 1'b1;
                    issued[i] <= 1'b0;
                    err[i]    <= 1'b0;
                end else if (fin[i]) begin
                    busy[i] <= 1'b0;
                end
                // Sticky until next kick
                if (done_hit[i]) begin
                    issued[i] <= 1'b0;
                    err[i]    <= err[i] | cmd.done_err;
                end
            end
            if (grant_ok) begin
                issued[grant_ch] <= 1'b1;
                last_grant       <= grant_ch;
                cmd_valid_r      <= 1'b1;
            end else if (cmd_valid_r && cmd.cmd_ready) begin
                cmd_valid_r <= 1'b0;
            end
        end
    end

    // Address and count advance by the finished burst
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CH; i++) begin
            if (kick_fire[i]) begin
                next_addr[i] <= kick_addr[i];
                remain[i]    <= kick_beats[i];
            end else if (done_hit[i]) begin
                next_addr[i] <= next_addr[i] + ADDR_W'(burst_sz[i]) * BEAT_BYTES;
                remain[i]    <= remain[i] - XFER_W'(burst_sz[i]);
            end
        end
        if (grant_ok) begin
            cmd_chan_r  <= grant_ch;
            cmd_addr_r  <= next_addr[grant_ch];
            cmd_beats_r <= burst_sz[grant_ch];
        end
    end

    assign cmd.cmd_valid = cmd_valid_r;
    assign cmd.cmd_chan  = cmd_chan_r;
    assign cmd.cmd_addr  = cmd_addr_r;
    assign cmd.cmd_beats = cmd_beats_r;

    // Every burst carries data
    a_beats_nonzero: assert property (
        @(posedge clk) disable iff (reset)
        cmd.cmd_valid |-> (cmd.cmd_beats != '0)
    ) else $error("channel_scheduler: zero-beat burst command");

    // Command held until the engine takes it
    a_cmd_stable: assert property (
        @(posedge clk) disable iff (reset)
        (cmd.cmd_valid && !cmd.cmd_ready) |=>
            (cmd.cmd_valid && $stable(cmd.cmd_chan) &&
             $stable(cmd.cmd_addr) && $stable(cmd.cmd_beats))
    ) else $error("channel_scheduler: command changed before accept");

endmodule : channel_scheduler

// ==== verilog/axi_write_engine.sv ====
/*
 * AXI4 write master for one burst at a time: address, data and
 * response phases in sequence, then a completion pulse
 */
`timescale 1ns/100ps

module axi_write_engine import dma_sink_pkg::*; (
    input  logic                clk,
    input  logic                reset,

    burst_cmd_if.engine         cmd,
    fill_rd_if.engine           rd,

    // Write address channel
    output logic                awvalid,
    input  logic                awready,
    output logic [ADDR_W-1:0]   awaddr,
    output logic [LEN_W-1:0]    awlen,
    output logic [CH_W-1:0]     awid,

    // Write data channel
    output logic                wvalid,
    input  logic                wready,
    output logic [DATA_W-1:0]   wdata,
    output logic                wlast,

    // Write response channel
    input  logic                bvalid,
    output logic                bready,
    input  logic [RESP_W-1:0]   bresp
);

    logic [ST_W-1:0]    state;
    logic               cmd_fire;
    logic               done_r;

    // Latched burst
    logic [CH_W-1:0]    chan_r;
    logic [ADDR_W-1:0]  addr_r;
    logic [BURST_W-1:0] beats_r;
    // Beats still to send
    logic [BURST_W-1:0] cnt;
    logic               err_r;

    assign cmd.cmd_ready = (state == ST_IDLE);
    assign cmd_fire      = cmd.cmd_valid && cmd.cmd_ready;

    // ==================================================
    // Phase sequencing
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= ST_IDLE;
            done_r <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (state)
                ST_IDLE: if (cmd_fire) state <= ST_ADDR;
                ST_ADDR: if (awready) state <= ST_DATA;
                ST_DATA: if (wready && wlast) state <= ST_RESP;
                ST_RESP: begin
                    if (bvalid) begin
                        state  <= ST_IDLE;
                        done_r <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            chan_r  <= cmd.cmd_chan;
            addr_r  <= cmd.cmd_addr;
            beats_r <= cmd.cmd_beats;
            cnt     <= cmd.cmd_beats;
        end else if (wvalid && wready) begin
            cnt <= cnt - 1'b1;
        end
        // Any non-OKAY code flags the burst
        if (bvalid && bready) begin
            err_r <= (bresp != RESP_OKAY);
        end
    end

    // AXI length is beats minus one
    assign awvalid = (state == ST_ADDR);
    assign awaddr  = addr_r;
    assign awlen   = LEN_W'(beats_r - 1'b1);
    assign awid    = chan_r;

    // Beats come straight off the buffer head
    assign wvalid     = (state == ST_DATA);
    assign wdata      = rd.rd_data;
    assign wlast      = (cnt == BURST_W'(1));
    assign rd.rd_chan = chan_r;
    assign rd.pop     = wvalid && wready;

    assign bready = (state == ST_RESP);

    // Completion one cycle after the response
    assign cmd.done      = done_r;
    assign cmd.done_chan = chan_r;
    assign cmd.done_err  = err_r;

    // Data only in the data phase, never past the burst end
    a_wvalid_phase: assert property (
        @(posedge clk) disable iff (reset)
        wvalid |-> (state == ST_DATA) && (cnt != '0)
    ) else $error("axi_write_engine: wvalid outside data phase");

endmodule : axi_write_engine

// ==== verilog/dma_sink_core.sv ====
/*
 * Four-channel network-to-memory data mover: fill buffer,
 * burst scheduler and AXI write engine behind plain ports
 */
`timescale 1ns/100ps

module dma_sink_core import dma_sink_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,

    // ==================================================
    // Per-channel kick
    // ==================================================
    input  logic [NUM_CH-1:0]             kick_valid,
    output logic [NUM_CH-1:0]             kick_ready,
    input  logic [NUM_CH-1:0][ADDR_W-1:0] kick_addr,
    input  logic [NUM_CH-1:0][XFER_W-1:0] kick_beats,

    // ==================================================
    // Fill stream
    // ==================================================
    input  logic                          fill_valid,
    output logic                          fill_ready,
    input  logic [CH_W-1:0]               fill_id,
    input  logic [DATA_W-1:0]             fill_data,
    output logic [NUM_CH-1:0][LVL_W-1:0]  space_free,

    // ==================================================
    // AXI4 write master
    // ==================================================
    output logic                          awvalid,
    input  logic                          awready,
    output logic [ADDR_W-1:0]             awaddr,
    output logic [LEN_W-1:0]              awlen,
    output logic [CH_W-1:0]               awid,
    output logic                          wvalid,
    input  logic                          wready,
    output logic [DATA_W-1:0]             wdata,
    output logic                          wlast,
    input  logic                          bvalid,
    output logic                          bready,
    input  logic [RESP_W-1:0]             bresp,

    // Status
    output logic [NUM_CH-1:0]             done_strobe,
    output logic [NUM_CH-1:0]             ch_error
);

    // Scheduler to engine, commands and completions
    burst_cmd_if u_cmd_bus ();
    // Buffer read side and levels
    fill_rd_if   u_rd_bus ();

    fill_buffer u_fill_buffer (
        .clk        (clk),
        .reset      (reset),
        .fill_valid (fill_valid),
        .fill_ready (fill_ready),
        .fill_id    (fill_id),
        .fill_data  (fill_data),
        .space_free (space_free),
        .rd         (u_rd_bus.buffer)
    );

    channel_scheduler u_scheduler (
        .clk         (clk),
        .reset       (reset),
        .kick_valid  (kick_valid),
        .kick_ready  (kick_ready),
        .kick_addr   (kick_addr),
        .kick_beats  (kick_beats),
        .done_strobe (done_strobe),
        .ch_error    (ch_error),
        .cmd         (u_cmd_bus.sched),
        .lvl         (u_rd_bus.sched)
    );

    axi_write_engine u_write_engine (
        .clk     (clk),
        .reset   (reset),
        .cmd     (u_cmd_bus.engine),
        .rd      (u_rd_bus.engine),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awid    (awid),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wlast   (wlast),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp)
    );

endmodule : dma_sink_core

// ==== dv/sink_checker.sv ====
/*
 * Scoreboard for the data mover: predicts bursts, addresses and
 * data per channel from the DUT ports and counts mismatches
 */
`timescale 1ns/100ps

module sink_checker import dma_sink_pkg::*; (
    input logic                          clk,
    input logic                          reset,
    input logic [NUM_CH-1:0]             kick_valid,
    input logic [NUM_CH-1:0]             kick_ready,
    input logic                          awvalid,
    input logic                          awready,
    input logic [ADDR_W-1:0]             awaddr,
    input logic [LEN_W-1:0]              awlen,
    input logic [CH_W-1:0]               awid,
    input logic                          wvalid,
    input logic                          wready,
    input logic [DATA_W-1:0]             wdata,
    input logic                          wlast,
    input logic                          bvalid,
    input logic                          bready,
    input logic [RESP_W-1:0]             bresp,
    input logic [NUM_CH-1:0]             done_strobe,
    input logic [NUM_CH-1:0]             ch_error
);

    int                errors = 0;
    int                checks = 0;
    int                tests = 0;
    int                test_err_base = 0;

    // Per-channel prediction
    logic [ADDR_W-1:0] exp_addr [NUM_CH];
    int                exp_rem [NUM_CH];
    logic [NUM_CH-1:0] exp_busy = '0;
    logic [NUM_CH-1:0] exp_err = '0;
    logic [DATA_W-1:0] exp_q [NUM_CH][$];

    // Burst in flight
    int                cur_ch = 0;
    int                cur_beats = 0;
    int                beat_idx = 0;

    task compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task flag_failure(input string what);
        errors++;
        $display("FAILURE: %s", what);
    endtask

    // Called by the stimulus as a kick is issued
    task expect_kick(input int ch, input logic [ADDR_W-1:0] addr, input int beats);
        exp_addr[ch] = addr;
        exp_rem[ch]  = beats;
        exp_err[ch]  = 1'b0;
    endtask

    task push_beat(input int ch, input logic [DATA_W-1:0] data);
        exp_q[ch].push_back(data);
    endtask

    task end_test(input int row);
        tests++;
        $display("test %0d: %0d errors", row, errors - test_err_base);
        test_err_base = errors;
    endtask

    // ==================================================
    // Port monitor
    // ==================================================

    always @(posedge clk) begin
        int size;
        int exp_ch;
        int n_act;
        logic [NUM_CH-1:0] exp_ready;
        if (!reset) begin
            // Ready exactly while idle
            exp_ready = ~exp_busy;
            compare_value("kick_ready", 32'(kick_ready), 32'(exp_ready));

            if (awvalid && awready) begin
                // Channels that still owe bursts
                exp_ch = -1;
                n_act  = 0;
                for (int ch = 0; ch < NUM_CH; ch++) begin
                    if (exp_busy[ch] && exp_rem[ch] != 0) begin
                        exp_ch = ch;
                        n_act++;
                    end
                end
                // Only one candidate, so the burst ID is known
                if (n_act == 1) begin
                    compare_value("awid", 32'(awid), 32'(exp_ch));
                    cur_ch = exp_ch;
                end else begin
                    cur_ch = int'(awid);
                end
                cur_beats = int'(awlen) + 1;
                beat_idx  = 0;
                if (!exp_busy[cur_ch] || exp_rem[cur_ch] == 0) begin
                    flag_failure("write burst on a channel with nothing left to send");
                end else begin
                    size = (exp_rem[cur_ch] < MAX_BURST) ? exp_rem[cur_ch] : MAX_BURST;
                    cur_beats = size;
                    compare_value("awaddr", awaddr, exp_addr[cur_ch]);
                    compare_value("awlen", 32'(awlen), 32'(size - 1));
                    exp_addr[cur_ch] = exp_addr[cur_ch] + ADDR_W'(size * BEAT_BYTES);
                    exp_rem[cur_ch]  = exp_rem[cur_ch] - size;
                end
            end

            if (wvalid && wready) begin
                if (exp_q[cur_ch].size() == 0) begin
                    flag_failure("write data beat with no fill beat expected");
                end else begin
                    compare_value("wdata", wdata, exp_q[cur_ch].pop_front());
                end
                compare_value("wlast", 32'(wlast), 32'(beat_idx == cur_beats - 1));
                beat_idx++;
            end

            // Sticky error expected from the response code
            if (bvalid && bready && bresp != RESP_OKAY) begin
                exp_err[cur_ch] = 1'b1;
            end

            for (int ch = 0; ch < NUM_CH; ch++) begin
                if (done_strobe[ch]) begin
                    if (!exp_busy[ch] || exp_rem[ch] != 0 || exp_q[ch].size() != 0) begin
                        flag_failure("done_strobe before the transfer finished");
                    end
                    compare_value("ch_error", 32'(ch_error), 32'(exp_err));
                    exp_busy[ch] = 1'b0;
                end
                if (kick_valid[ch] && kick_ready[ch]) begin
                    exp_busy[ch] = 1'b1;
                end
            end
        end
    end

endmodule : sink_checker

// ==== dv/tb_dma_sink.sv ====
/*
 * Testbench for the data mover: table of kicks, fill driver and
 * AXI memory model with optional stalls and error responses
 */
`timescale 1ns/100ps

module tb_dma_sink import dma_sink_pkg::*; ();

    logic                          clk = 1'b0;
    logic                          reset;
    logic [NUM_CH-1:0]             kick_valid;
    logic [NUM_CH-1:0]             kick_ready;
    logic [NUM_CH-1:0][ADDR_W-1:0] kick_addr;
    logic [NUM_CH-1:0][XFER_W-1:0] kick_beats;
    logic                          fill_valid;
    logic                          fill_ready;
    logic [CH_W-1:0]               fill_id;
    logic [DATA_W-1:0]             fill_data;
    logic [NUM_CH-1:0][LVL_W-1:0]  space_free;
    logic                          awvalid;
    logic                          awready = 1'b0;
    logic [ADDR_W-1:0]             awaddr;
    logic [LEN_W-1:0]              awlen;
    logic [CH_W-1:0]               awid;
    logic                          wvalid;
    logic                          wready = 1'b0;
    logic [DATA_W-1:0]             wdata;
    logic                          wlast;
    logic                          bvalid = 1'b0;
    logic                          bready;
    logic [RESP_W-1:0]             bresp = RESP_OKAY;
    logic [NUM_CH-1:0]             done_strobe;
    logic [NUM_CH-1:0]             ch_error;

    integer seed = 32'h2108_4e88;

    // Stimulus table
    int n_rows = 0;
    int row_ch [16];
    logic [ADDR_W-1:0] row_addr [16];
    int row_beats [16];
    int row_stall [16];
    int row_err [16];
    int row_group [16];
    int row_hold [16];

    // Memory model controls
    int stall_mode = 0;
    int err_ch = -1;
    int err_at = -1;
    int aw_count [NUM_CH] = '{default: 0};
    logic aw_is_err = 1'b0;
    logic b_pending = 1'b0;
    int done_seen [NUM_CH] = '{default: 0};

    always #20 clk = ~clk;

    dma_sink_core uut (.*);

    sink_checker u_checker (
        .clk (clk), .reset (reset), .kick_valid (kick_valid), .kick_ready (kick_ready),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr), .awlen (awlen),
        .awid (awid), .wvalid (wvalid), .wready (wready), .wdata (wdata), .wlast (wlast),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .done_strobe (done_strobe), .ch_error (ch_error)
    );

    // ==================================================
    // AXI memory model
    // ==================================================

    always @(posedge clk) begin
        if (awvalid && awready) begin
            aw_is_err      <= (int'(awid) == err_ch) && (aw_count[awid] == err_at);
            aw_count[awid] <= aw_count[awid] + 1;
        end
        if (wvalid && wready && wlast) begin
            b_pending <= 1'b1;
        end
        if (bvalid && bready) begin
            b_pending <= 1'b0;
        end
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (!reset && done_strobe[ch]) begin
                done_seen[ch] <= done_seen[ch] + 1;
            end
        end
    end

    // Random stalls only on rows that ask for them
    always @(negedge clk) begin
        awready <= (stall_mode == 0) || (($random(seed) & 3) != 0);
        wready  <= (stall_mode == 0) || (($random(seed) & 3) != 0);
        bvalid  <= b_pending;
        bresp   <= (b_pending && aw_is_err) ? 2'b10 : RESP_OKAY;
    end

    task timeout_failure(input string what);
        $display("FAILURE: timed out waiting for %s", what);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    task add_row(input int ch, input logic [ADDR_W-1:0] addr, input int beats,
                 input int stall, input int err, input int group, input int hold);
        row_ch[n_rows]    = ch;
        row_addr[n_rows]  = addr;
        row_beats[n_rows] = beats;
        row_stall[n_rows] = stall;
        row_err[n_rows]   = err;
        row_group[n_rows] = group;
        row_hold[n_rows]  = hold;
        n_rows++;
    endtask

    // One fill beat, entered and left on a falling edge
    task push_fill(input int ch);
        int t;
        logic [DATA_W-1:0] data;
        data       = $random(seed);
        fill_valid = 1'b1;
        fill_id    = CH_W'(ch);
        fill_data  = data;
        #1;
        t = 0;
        while (!fill_ready) begin
            @(negedge clk);
            #1;
            t++;
            if (t > 2000) timeout_failure("fill_ready");
        end
        u_checker.push_beat(ch, data);
        @(negedge clk);
        fill_valid = 1'b0;
    endtask

    task kick_channel(input int r);
        int t;
        int ch;
        ch = row_ch[r];
        t  = 0;
        while (!kick_ready[ch]) begin
            @(negedge clk);
            t++;
            if (t > 5000) timeout_failure("kick_ready");
        end
        if (row_err[r] >= 0) begin
            err_ch = ch;
            err_at = aw_count[ch] + row_err[r];
        end
        u_checker.expect_kick(ch, row_addr[r], row_beats[r]);
        kick_valid[ch] = 1'b1;
        kick_addr[ch]  = row_addr[r];
        kick_beats[ch] = XFER_W'(row_beats[r]);
        @(negedge clk);
        kick_valid[ch] = 1'b0;
        // Flag from an earlier transfer is gone
        u_checker.compare_value("ch_error", 32'(ch_error[ch]), 32'(0));
    endtask

    task run_rows(input int first, input int last);
        int sent [16];
        int base [16];
        int more;
        int t;
        int ch;
        stall_mode = row_stall[first];
        if (row_hold[first] != 0) begin
            // Fill with the kick held back, buffer fills up
            ch = row_ch[first];
            for (int b = 0; b < row_beats[first]; b++) begin
                push_fill(ch);
                if (b == 7) begin
                    u_checker.compare_value("space_free", 32'(space_free[ch]),
                                            32'(BUF_DEPTH - 8));
                end
            end
            fill_id = CH_W'(ch);
            #1;
            u_checker.compare_value("fill_ready", 32'(fill_ready), 32'(0));
            u_checker.compare_value("space_free", 32'(space_free[ch]),
                                    32'(BUF_DEPTH - row_beats[first]));
        end
        for (int r = first; r <= last; r++) begin
            base[r] = done_seen[row_ch[r]];
            sent[r] = (row_hold[r] != 0) ? row_beats[r] : 0;
            kick_channel(r);
        end
        // Alternate beats across the rows of a group
        more = 1;
        while (more != 0) begin
            more = 0;
            for (int r = first; r <= last; r++) begin
                if (sent[r] < row_beats[r]) begin
                    push_fill(row_ch[r]);
                    sent[r]++;
                    more = 1;
                end
            end
        end
        for (int r = first; r <= last; r++) begin
            t = 0;
            while (done_seen[row_ch[r]] == base[r]) begin
                @(negedge clk);
                t++;
                if (t > 5000) timeout_failure("done_strobe");
            end
        end
        stall_mode = 0;
        err_ch     = -1;
        for (int r = first; r <= last; r++) begin
            u_checker.end_test(r);
        end
    endtask

    initial begin
        int r;
        int last;
        reset      = 1'b1;
        kick_valid = '0;
        kick_addr  = '0;
        kick_beats = '0;
        fill_valid = 1'b0;
        fill_id    = '0;
        fill_data  = '0;

        // ch, addr, beats, stall, error burst, group, hold
        add_row(1, 32'h1000_0000, 12, 0, -1, 0, 0);
        add_row(0, 32'h2000_0100, 6, 0, -1, 0, 0);
        add_row(0, 32'h3000_0000, 8, 0, -1, 1, 0);
        add_row(2, 32'h3100_0040, 10, 0, -1, 1, 0);
        add_row(3, 32'h4000_0000, 16, 1, -1, 0, 1);
        add_row(2, 32'h5000_0000, 9, 0, 1, 0, 0);
        add_row(2, 32'h5100_0000, 5, 0, -1, 0, 0);

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        u_checker.compare_value("awvalid", 32'(awvalid), 32'(0));
        u_checker.compare_value("wvalid", 32'(wvalid), 32'(0));
        u_checker.compare_value("bready", 32'(bready), 32'(0));
        u_checker.compare_value("done_strobe", 32'(done_strobe), 32'(0));
        u_checker.compare_value("ch_error", 32'(ch_error), 32'(0));
        for (int ch = 0; ch < NUM_CH; ch++) begin
            u_checker.compare_value("space_free", 32'(space_free[ch]), 32'(BUF_DEPTH));
        end

        r = 0;
        while (r < n_rows) begin
            last = r;
            while (row_group[r] != 0 && last + 1 < n_rows &&
                   row_group[last + 1] == row_group[r]) begin
                last++;
            end
            run_rows(r, last);
            r = last + 1;
        end

        repeat (5) @(negedge clk);
        $display("tests %0d, checks %0d, errors %0d",
                 u_checker.tests, u_checker.checks, u_checker.errors);
        if (u_checker.errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_dma_sink

// ==== build.f ====
verilog/dma_sink_pkg.sv
verilog/dma_sink_if.sv
verilog/fill_buffer.sv
verilog/channel_scheduler.sv
verilog/axi_write_engine.sv
verilog/dma_sink_core.sv
dv/sink_checker.sv
dv/tb_dma_sink.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the data mover testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_dma_sink -Mdir obj_dir -o sim_dma_sink
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

./obj_dir/sim_dma_sink > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST FAILED ***" sim.log; then
    exit 1
fi
if ! grep -qF "*** TEST PASSED ***" sim.log; then
    echo "No result line in sim.log"
    exit 1
fi
exit 0
